// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int LINE_WORDS = 4;
	localparam int SET_ASSOC  = 2;
	localparam int SET_COUNT  = 16;

	// byte offset inside a word, then inside a line
	localparam int WORD_OFFSET_WIDTH = $clog2(STRB_WIDTH);
	localparam int LINE_OFFSET_WIDTH = WORD_OFFSET_WIDTH + $clog2(LINE_WORDS);
	localparam int INDEX_WIDTH       = $clog2(SET_COUNT);
	localparam int TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET_WIDTH;
	localparam int WAY_WIDTH         = $clog2(SET_ASSOC);

	typedef logic [DATA_WIDTH-1:0] word_t;
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef word_t [LINE_WORDS-1:0] line_t;

	typedef enum logic [1:0] {
		IC_IDLE,
		IC_REFILL_ADDR,
		IC_REFILL_DATA,
		IC_FINISH
	} icache_state_t;

	typedef enum logic [2:0] {
		DP_IDLE,
		DP_READ_ADDR,
		DP_READ_DATA,
		DP_WRITE,
		DP_WRITE_RESP
	} dport_state_t;

	typedef enum logic [1:0] {
		OWNER_NONE,
		OWNER_ICACHE,
		OWNER_DPORT
	} arb_owner_t;

endpackage

`default_nettype wire

// File: single_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module single_port_ram #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [WIDTH-1:0]         din,
	output logic [WIDTH-1:0]         dout
);

	logic [WIDTH-1:0] mem [DEPTH];

	// write-first: a write shows up on dout the same edge
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			dout <= '0;
		end else if (we) begin
			mem[addr] <= din;
			dout      <= din;
		end else begin
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetch_read,
	input  cache_pkg::addr_t fetch_addr,
	output logic             fetch_stall,
	output logic             fetch_valid,
	output cache_pkg::word_t fetch_data,
	output logic             arvalid,
	output cache_pkg::addr_t araddr,
	output logic             rready,
	input  logic             arready,
	input  logic             rvalid,
	input  cache_pkg::word_t rdata
);

	import cache_pkg::*;

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	icache_state_t state;
	addr_t         req_addr;
	logic          lookup, compare;
	logic          accept, hit_done, miss, line_we;

	logic [INDEX_WIDTH-1:0] req_index;
	logic [TAG_WIDTH-1:0]   req_tag;
	logic [LINE_OFFSET_WIDTH-WORD_OFFSET_WIDTH-1:0] req_word, beat_cnt;

	tag_entry_t [SET_ASSOC-1:0] tag_rdata;
	line_t      [SET_ASSOC-1:0] line_rdata;
	logic       [SET_ASSOC-1:0] way_hit, way_we;
	tag_entry_t tag_wdata;
	line_t      line_wdata, line_buf;
	word_t      hit_word;

	logic [7:0]           lfsr;
	logic [WAY_WIDTH-1:0] victim;

	assign req_index = req_addr[LINE_OFFSET_WIDTH +: INDEX_WIDTH];
	assign req_tag   = req_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign req_word  = req_addr[WORD_OFFSET_WIDTH +: LINE_OFFSET_WIDTH - WORD_OFFSET_WIDTH];

	// one fetch in flight: lookup is the RAM read cycle, compare the tag check
	assign fetch_stall = lookup | compare | (state != IC_IDLE);
	assign accept      = fetch_read & ~fetch_stall;
	assign hit_done    = compare & (|way_hit) & (state == IC_IDLE);
	assign miss        = compare & ~(|way_hit) & (state == IC_IDLE);

	always_comb begin
		hit_word = '0;
		for (int i = 0; i < SET_ASSOC; i++) begin
			if (way_hit[i]) begin
				hit_word = line_rdata[i][req_word];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lookup      <= 1'b0;
			compare     <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			lookup      <= accept;
			compare     <= lookup | (compare & ~hit_done);
			fetch_valid <= hit_done;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= fetch_addr;
		end
		if (hit_done) begin
			fetch_data <= hit_word;
		end
		if (rvalid && rready) begin
			line_buf[beat_cnt] <= rdata;
		end
	end

	// refill, one single-beat read per word
	assign arvalid = (state == IC_REFILL_ADDR);
	assign rready  = (state == IC_REFILL_DATA);
	assign araddr  = {req_addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH], beat_cnt,
		{WORD_OFFSET_WIDTH{1'b0}}};

	// beat_cnt all ones is the last word of the line
	assign line_we = rvalid & rready & (&beat_cnt);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IC_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				IC_IDLE: begin
					if (miss) begin
						state    <= IC_REFILL_ADDR;
						beat_cnt <= '0;
					end
				end
				IC_REFILL_ADDR: begin
					if (arready) begin
						state <= IC_REFILL_DATA;
					end
				end
				IC_REFILL_DATA: begin
					if (rvalid && (&beat_cnt)) begin
						state <= IC_FINISH;
					end else if (rvalid) begin
						beat_cnt <= beat_cnt + 1'b1;
						state    <= IC_REFILL_ADDR;
					end
				end
				// RAMs re-read the new line here
				IC_FINISH: state <= IC_IDLE;
				default:   state <= IC_IDLE;
			endcase
		end
	end

	always_comb begin
		line_wdata                 = line_buf;
		line_wdata[LINE_WORDS-1]   = rdata;
	end
	assign tag_wdata = '{valid: 1'b1, tag: req_tag};

	// random victim, x^8+x^6+x^5+x^4+1
	assign victim = lfsr[WAY_WIDTH-1:0];
	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= 8'h01;
		end else if (line_we) begin
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
	end

	for (genvar i = 0; i < SET_ASSOC; i++) begin : gen_way
		assign way_we[i]  = line_we & (victim == WAY_WIDTH'(i));
		assign way_hit[i] = tag_rdata[i].valid & (tag_rdata[i].tag == req_tag);

		single_port_ram #(
			.DEPTH ( SET_COUNT           ),
			.WIDTH ( $bits(tag_entry_t)  )
		) tag_ram (
			.clk  ( clk          ),
			.rst  ( rst          ),
			.we   ( way_we[i]    ),
			.addr ( req_index    ),
			.din  ( tag_wdata    ),
			.dout ( tag_rdata[i] )
		);

		single_port_ram #(
			.DEPTH ( SET_COUNT     ),
			.WIDTH ( $bits(line_t) )
		) line_ram (
			.clk  ( clk           ),
			.rst  ( rst           ),
			.we   ( way_we[i]     ),
			.addr ( req_index     ),
			.din  ( line_wdata    ),
			.dout ( line_rdata[i] )
		);
	end

	a_valid_not_stalled: assert property (@(posedge clk) disable iff (rst)
		!(fetch_valid && fetch_stall));

	a_araddr_held: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

// File: data_port.sv
`timescale 1ns/100ps
`default_nettype none

module data_port (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             data_req,
	input  logic                             data_we,
	input  cache_pkg::addr_t                 data_addr,
	input  cache_pkg::word_t                 data_wdata,
	input  logic [cache_pkg::STRB_WIDTH-1:0] data_wstrb,
	output logic                             data_busy,
	output logic                             data_done,
	output cache_pkg::word_t                 data_rdata,
	output logic                             arvalid,
	output cache_pkg::addr_t                 araddr,
	output logic                             rready,
	output logic                             awvalid,
	output cache_pkg::addr_t                 awaddr,
	output logic                             wvalid,
	output cache_pkg::word_t                 wdata,
	output logic [cache_pkg::STRB_WIDTH-1:0] wstrb,
	output logic                             bready,
	input  logic                             arready,
	input  logic                             rvalid,
	input  cache_pkg::word_t                 rdata,
	input  logic                             awready,
	input  logic                             wready,
	input  logic                             bvalid
);

	import cache_pkg::*;

	dport_state_t           state;
	addr_t                  req_addr;
	word_t                  req_wdata;
	logic [STRB_WIDTH-1:0]  req_wstrb;
	logic                   aw_pending, w_pending;
	logic                   accept, write_sent;

	assign data_busy  = (state != DP_IDLE);
	assign accept     = data_req & ~data_busy;
	// both halves of the write taken now or earlier
	assign write_sent = (~aw_pending | awready) & (~w_pending | wready);

	assign arvalid = (state == DP_READ_ADDR);
	assign rready  = (state == DP_READ_DATA);
	assign awvalid = (state == DP_WRITE) & aw_pending;
	assign wvalid  = (state == DP_WRITE) & w_pending;
	assign bready  = (state == DP_WRITE_RESP);
	assign araddr  = req_addr;
	assign awaddr  = req_addr;
	assign wdata   = req_wdata;
	assign wstrb   = req_wstrb;

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr  <= data_addr;
			req_wdata <= data_wdata;
			req_wstrb <= data_wstrb;
		end
		if (rvalid && rready) begin
			data_rdata <= rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= DP_IDLE;
			data_done  <= 1'b0;
			aw_pending <= 1'b0;
			w_pending  <= 1'b0;
		end else begin
			data_done <= 1'b0;
			case (state)
				DP_IDLE: begin
					if (accept && data_we) begin
						state      <= DP_WRITE;
						aw_pending <= 1'b1;
						w_pending  <= 1'b1;
					end else if (accept) begin
						state <= DP_READ_ADDR;
					end
				end
				DP_READ_ADDR: begin
					if (arready) begin
						state <= DP_READ_DATA;
					end
				end
				DP_READ_DATA: begin
					if (rvalid) begin
						state     <= DP_IDLE;
						data_done <= 1'b1;
					end
				end
				DP_WRITE: begin
					if (awready) begin
						aw_pending <= 1'b0;
					end
					if (wready) begin
						w_pending <= 1'b0;
					end
					if (write_sent) begin
						state <= DP_WRITE_RESP;
					end
				end
				DP_WRITE_RESP: begin
					if (bvalid) begin
						state     <= DP_IDLE;
						data_done <= 1'b1;
					end
				end
				default: state <= DP_IDLE;
			endcase
		end
	end

	a_aw_held: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr));

	a_w_held: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb));

endmodule

`default_nettype wire

// File: axi_lite_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_arbiter (
	input  logic                             clk,
	input  logic                             rst,
	// icache reads only
	input  logic                             ic_arvalid,
	input  cache_pkg::addr_t                 ic_araddr,
	output logic                             ic_arready,
	output logic                             ic_rvalid,
	output cache_pkg::word_t                 ic_rdata,
	input  logic                             ic_rready,
	// data port
	input  logic                             dp_arvalid,
	input  cache_pkg::addr_t                 dp_araddr,
	output logic                             dp_arready,
	output logic                             dp_rvalid,
	output cache_pkg::word_t                 dp_rdata,
	input  logic                             dp_rready,
	input  logic                             dp_awvalid,
	input  cache_pkg::addr_t                 dp_awaddr,
	output logic                             dp_awready,
	input  logic                             dp_wvalid,
	input  cache_pkg::word_t                 dp_wdata,
	input  logic [cache_pkg::STRB_WIDTH-1:0] dp_wstrb,
	output logic                             dp_wready,
	output logic                             dp_bvalid,
	input  logic                             dp_bready,
	// shared master port
	output logic                             m_arvalid,
	output cache_pkg::addr_t                 m_araddr,
	input  logic                             m_arready,
	input  logic                             m_rvalid,
	input  cache_pkg::word_t                 m_rdata,
	output logic                             m_rready,
	output logic                             m_awvalid,
	output cache_pkg::addr_t                 m_awaddr,
	input  logic                             m_awready,
	output logic                             m_wvalid,
	output cache_pkg::word_t                 m_wdata,
	output logic [cache_pkg::STRB_WIDTH-1:0] m_wstrb,
	input  logic                             m_wready,
	input  logic                             m_bvalid,
	output logic                             m_bready
);

	import cache_pkg::*;

	arb_owner_t owner;
	logic       last_dport;
	logic       ic_req, dp_req, ic_own, dp_own, done;

	assign ic_req = ic_arvalid;
	assign dp_req = dp_arvalid | dp_awvalid;
	assign ic_own = (owner == OWNER_ICACHE);
	assign dp_own = (owner == OWNER_DPORT);
	assign done   = (m_rvalid & m_rready) | (m_bvalid & m_bready);

	always_ff @(posedge clk) begin
		if (rst) begin
			owner      <= OWNER_NONE;
			last_dport <= 1'b0;
		end else begin
			case (owner)
				OWNER_NONE: begin
					// on a tie the peer not granted last goes first
					if (ic_req && (!dp_req || last_dport)) begin
						owner      <= OWNER_ICACHE;
						last_dport <= 1'b0;
					end else if (dp_req) begin
						owner      <= OWNER_DPORT;
						last_dport <= 1'b1;
					end
				end
				OWNER_ICACHE, OWNER_DPORT: begin
					if (done) begin
						owner <= OWNER_NONE;
					end
				end
				default: owner <= OWNER_NONE;
			endcase
		end
	end

	// requests from the owner only
	assign m_arvalid = (ic_own & ic_arvalid) | (dp_own & dp_arvalid);
	assign m_araddr  = ic_own ? ic_araddr : dp_araddr;
	assign m_rready  = (ic_own & ic_rready) | (dp_own & dp_rready);
	assign m_awvalid = dp_own & dp_awvalid;
	assign m_awaddr  = dp_awaddr;
	assign m_wvalid  = dp_own & dp_wvalid;
	assign m_wdata   = dp_wdata;
	assign m_wstrb   = dp_wstrb;
	assign m_bready  = dp_own & dp_bready;

	// readies and responses back to the owner
	assign ic_arready = ic_own & m_arready;
	assign ic_rvalid  = ic_own & m_rvalid;
	assign ic_rdata   = m_rdata;
	assign dp_arready = dp_own & m_arready;
	assign dp_rvalid  = dp_own & m_rvalid;
	assign dp_rdata   = m_rdata;
	assign dp_awready = dp_own & m_awready;
	assign dp_wready  = dp_own & m_wready;
	assign dp_bvalid  = dp_own & m_bvalid;

	a_ar_held: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr));

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             fetch_read,
	input  cache_pkg::addr_t                 fetch_addr,
	output logic                             fetch_stall,
	output logic                             fetch_valid,
	output cache_pkg::word_t                 fetch_data,
	input  logic                             data_req,
	input  logic                             data_we,
	input  cache_pkg::addr_t                 data_addr,
	input  cache_pkg::word_t                 data_wdata,
	input  logic [cache_pkg::STRB_WIDTH-1:0] data_wstrb,
	output logic                             data_busy,
	output logic                             data_done,
	output cache_pkg::word_t                 data_rdata,
	output logic                             m_arvalid,
	output cache_pkg::addr_t                 m_araddr,
	input  logic                             m_arready,
	input  logic                             m_rvalid,
	input  cache_pkg::word_t                 m_rdata,
	output logic                             m_rready,
	output logic                             m_awvalid,
	output cache_pkg::addr_t                 m_awaddr,
	input  logic                             m_awready,
	output logic                             m_wvalid,
	output cache_pkg::word_t                 m_wdata,
	output logic [cache_pkg::STRB_WIDTH-1:0] m_wstrb,
	input  logic                             m_wready,
	input  logic                             m_bvalid,
	output logic                             m_bready
);

	import cache_pkg::*;

	logic                  ic_arvalid, ic_arready, ic_rvalid, ic_rready;
	addr_t                 ic_araddr;
	word_t                 ic_rdata;
	logic                  dp_arvalid, dp_arready, dp_rvalid, dp_rready;
	logic                  dp_awvalid, dp_awready, dp_wvalid, dp_wready;
	logic                  dp_bvalid, dp_bready;
	addr_t                 dp_araddr, dp_awaddr;
	word_t                 dp_rdata, dp_wdata;
	logic [STRB_WIDTH-1:0] dp_wstrb;

	icache u_icache (
		.clk         ( clk         ),
		.rst         ( rst         ),
		.fetch_read  ( fetch_read  ),
		.fetch_addr  ( fetch_addr  ),
		.fetch_stall ( fetch_stall ),
		.fetch_valid ( fetch_valid ),
		.fetch_data  ( fetch_data  ),
		.arvalid     ( ic_arvalid  ),
		.araddr      ( ic_araddr   ),
		.rready      ( ic_rready   ),
		.arready     ( ic_arready  ),
		.rvalid      ( ic_rvalid   ),
		.rdata       ( ic_rdata    )
	);

	data_port u_data_port (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.data_req   ( data_req   ),
		.data_we    ( data_we    ),
		.data_addr  ( data_addr  ),
		.data_wdata ( data_wdata ),
		.data_wstrb ( data_wstrb ),
		.data_busy  ( data_busy  ),
		.data_done  ( data_done  ),
		.data_rdata ( data_rdata ),
		.arvalid    ( dp_arvalid ),
		.araddr     ( dp_araddr  ),
		.rready     ( dp_rready  ),
		.awvalid    ( dp_awvalid ),
		.awaddr     ( dp_awaddr  ),
		.wvalid     ( dp_wvalid  ),
		.wdata      ( dp_wdata   ),
		.wstrb      ( dp_wstrb   ),
		.bready     ( dp_bready  ),
		.arready    ( dp_arready ),
		.rvalid     ( dp_rvalid  ),
		.rdata      ( dp_rdata   ),
		.awready    ( dp_awready ),
		.wready     ( dp_wready  ),
		.bvalid     ( dp_bvalid  )
	);

	axi_lite_arbiter u_arbiter (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.ic_arvalid ( ic_arvalid ),
		.ic_araddr  ( ic_araddr  ),
		.ic_arready ( ic_arready ),
		.ic_rvalid  ( ic_rvalid  ),
		.ic_rdata   ( ic_rdata   ),
		.ic_rready  ( ic_rready  ),
		.dp_arvalid ( dp_arvalid ),
		.dp_araddr  ( dp_araddr  ),
		.dp_arready ( dp_arready ),
		.dp_rvalid  ( dp_rvalid  ),
		.dp_rdata   ( dp_rdata   ),
		.dp_rready  ( dp_rready  ),
		.dp_awvalid ( dp_awvalid ),
		.dp_awaddr  ( dp_awaddr  ),
		.dp_awready ( dp_awready ),
		.dp_wvalid  ( dp_wvalid  ),
		.dp_wdata   ( dp_wdata   ),
		.dp_wstrb   ( dp_wstrb   ),
		.dp_wready  ( dp_wready  ),
		.dp_bvalid  ( dp_bvalid  ),
		.dp_bready  ( dp_bready  ),
		.m_arvalid  ( m_arvalid  ),
		.m_araddr   ( m_araddr   ),
		.m_arready  ( m_arready  ),
		.m_rvalid   ( m_rvalid   ),
		.m_rdata    ( m_rdata    ),
		.m_rready   ( m_rready   ),
		.m_awvalid  ( m_awvalid  ),
		.m_awaddr   ( m_awaddr   ),
		.m_awready  ( m_awready  ),
		.m_wvalid   ( m_wvalid   ),
		.m_wdata    ( m_wdata    ),
		.m_wstrb    ( m_wstrb    ),
		.m_wready   ( m_wready   ),
		.m_bvalid   ( m_bvalid   ),
		.m_bready   ( m_bready   )
	);

endmodule

`default_nettype wire

// File: axi_lite_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module axi_lite_mem_model (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             arvalid,
	input  cache_pkg::addr_t                 araddr,
	output logic                             arready,
	output logic                             rvalid,
	output cache_pkg::word_t                 rdata,
	input  logic                             rready,
	input  logic                             awvalid,
	input  cache_pkg::addr_t                 awaddr,
	output logic                             awready,
	input  logic                             wvalid,
	input  cache_pkg::word_t                 wdata,
	input  logic [cache_pkg::STRB_WIDTH-1:0] wstrb,
	output logic                             wready,
	output logic                             bvalid,
	input  logic                             bready
);

	import cache_pkg::*;

	word_t                 mem [addr_t];
	logic [31:0]           rng;
	logic [1:0]            ar_wait, r_wait, aw_wait, w_wait;
	logic                  r_pend, aw_got, w_got;
	addr_t                 wr_addr;
	word_t                 wr_data, merged;
	logic [STRB_WIDTH-1:0] wr_strb;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic addr_t word_key(input addr_t a);
		return {a[ADDR_WIDTH-1:WORD_OFFSET_WIDTH], {WORD_OFFSET_WIDTH{1'b0}}};
	endfunction

	// unwritten words follow the address pattern
	function automatic word_t read_word(input addr_t a);
		if (mem.exists(word_key(a))) begin
			return mem[word_key(a)];
		end
		return word_key(a) ^ 32'h5a5a0000;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			rng = 32'hdd9a9aa9;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			ar_wait <= 2'd0;
			r_wait  <= 2'd0;
			aw_wait <= 2'd0;
			w_wait  <= 2'd0;
			r_pend  <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
		end else begin
			rng = xorshift(rng);
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;

			// read address, then a random gap before the data
			if (arvalid && arready) begin
				rdata  <= read_word(araddr);
				r_pend <= 1'b1;
				r_wait <= rng[1:0];
			end else if (arvalid && !r_pend && !rvalid) begin
				if (ar_wait == 2'd0) begin
					arready <= 1'b1;
					ar_wait <= rng[9:8];
				end else begin
					ar_wait <= ar_wait - 2'd1;
				end
			end
			if (r_pend && r_wait == 2'd0) begin
				rvalid <= 1'b1;
				r_pend <= 1'b0;
			end else if (r_pend) begin
				r_wait <= r_wait - 2'd1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end

			// aw and w accepted independently
			if (awvalid && awready) begin
				aw_got  <= 1'b1;
				wr_addr <= awaddr;
			end else if (awvalid && !aw_got) begin
				if (aw_wait == 2'd0) begin
					awready <= 1'b1;
					aw_wait <= rng[17:16];
				end else begin
					aw_wait <= aw_wait - 2'd1;
				end
			end
			if (wvalid && wready) begin
				w_got   <= 1'b1;
				wr_data <= wdata;
				wr_strb <= wstrb;
			end else if (wvalid && !w_got) begin
				if (w_wait == 2'd0) begin
					wready <= 1'b1;
					w_wait <= rng[25:24];
				end else begin
					w_wait <= w_wait - 2'd1;
				end
			end

			// byte merge once both halves are in
			if (aw_got && w_got && !bvalid) begin
				merged = read_word(wr_addr);
				for (int i = 0; i < STRB_WIDTH; i++) begin
					if (wr_strb[i]) begin
						merged[8*i +: 8] = wr_data[8*i +: 8];
					end
				end
				mem[word_key(wr_addr)] = merged;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				bvalid <= 1'b1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

	import cache_pkg::*;

	localparam int WAIT_LIMIT = 400;
	localparam int NUM_TESTS  = 17;

	typedef enum logic [1:0] {
		K_FETCH,
		K_LOAD,
		K_STORE,
		K_PAIR
	} kind_t;

	// addr2 is the load address of a paired entry
	typedef struct packed {
		kind_t                 kind;
		addr_t                 addr;
		addr_t                 addr2;
		word_t                 wdata;
		logic [STRB_WIDTH-1:0] strb;
		logic                  hit;
	} entry_t;

	logic                  clk, rst;
	logic                  fetch_read, fetch_stall, fetch_valid;
	addr_t                 fetch_addr;
	word_t                 fetch_data;
	logic                  data_req, data_we, data_busy, data_done;
	addr_t                 data_addr;
	word_t                 data_wdata, data_rdata;
	logic [STRB_WIDTH-1:0] data_wstrb;
	logic                  m_arvalid, m_arready, m_rvalid, m_rready;
	logic                  m_awvalid, m_awready, m_wvalid, m_wready, m_bvalid, m_bready;
	addr_t                 m_araddr, m_awaddr;
	word_t                 m_rdata, m_wdata;
	logic [STRB_WIDTH-1:0] m_wstrb;

	entry_t stim [NUM_TESTS];
	word_t  shadow [addr_t];
	int     errors, ar_count;

	mem_subsys_top UUT (.*);

	axi_lite_mem_model u_mem (
		.clk     ( clk       ),
		.rst     ( rst       ),
		.arvalid ( m_arvalid ),
		.araddr  ( m_araddr  ),
		.arready ( m_arready ),
		.rvalid  ( m_rvalid  ),
		.rdata   ( m_rdata   ),
		.rready  ( m_rready  ),
		.awvalid ( m_awvalid ),
		.awaddr  ( m_awaddr  ),
		.awready ( m_awready ),
		.wvalid  ( m_wvalid  ),
		.wdata   ( m_wdata   ),
		.wstrb   ( m_wstrb   ),
		.wready  ( m_wready  ),
		.bvalid  ( m_bvalid  ),
		.bready  ( m_bready  )
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// count of external read handshakes
	always @(posedge clk) begin
		if (rst) begin
			ar_count <= 0;
		end else if (m_arvalid && m_arready) begin
			ar_count <= ar_count + 1;
		end
	end

	function automatic word_t expected_word(input addr_t a);
		addr_t key;
		key = {a[ADDR_WIDTH-1:WORD_OFFSET_WIDTH], {WORD_OFFSET_WIDTH{1'b0}}};
		if (shadow.exists(key)) begin
			return shadow[key];
		end
		return key ^ 32'h5a5a0000;
	endfunction

	task automatic record_store(input addr_t a, input word_t d, input logic [STRB_WIDTH-1:0] s);
		word_t w;
		w = expected_word(a);
		for (int i = 0; i < STRB_WIDTH; i++) begin
			if (s[i]) begin
				w[8*i +: 8] = d[8*i +: 8];
			end
		end
		shadow[{a[ADDR_WIDTH-1:WORD_OFFSET_WIDTH], {WORD_OFFSET_WIDTH{1'b0}}}] = w;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			$display("** Error %s exp 0x%h got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("** Error %s exp 0x%h got 0x%h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int got);
		if (got != exp) begin
			$display("** Error %s exp 0x%0h got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	task automatic run_fetch(input addr_t a, output word_t data, output int lat,
		output int reads);
		int n;
		int start;
		data  = '0;
		lat   = -1;
		reads = -1;
		@(posedge clk);
		fetch_read <= 1'b1;
		fetch_addr <= a;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (!fetch_stall) break;
		end
		fetch_read <= 1'b0;
		if (n == WAIT_LIMIT) begin
			$display("fetch of 0x%h was never accepted", a);
			errors++;
			return;
		end
		start = ar_count;
		for (n = 1; n <= WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (fetch_valid) break;
		end
		if (n > WAIT_LIMIT) begin
			$display("fetch of 0x%h never returned data", a);
			errors++;
			return;
		end
		data  = fetch_data;
		// value seen here was set by the edge before
		lat   = n - 1;
		reads = ar_count - start;
	endtask

	task automatic run_data(input logic we, input addr_t a, input word_t d,
		input logic [STRB_WIDTH-1:0] s, output word_t rdata);
		int n;
		rdata = '0;
		@(posedge clk);
		data_req   <= 1'b1;
		data_we    <= we;
		data_addr  <= a;
		data_wdata <= d;
		data_wstrb <= s;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (!data_busy) break;
		end
		data_req <= 1'b0;
		if (n == WAIT_LIMIT) begin
			$display("data access to 0x%h was never accepted", a);
			errors++;
			return;
		end
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(posedge clk);
			if (data_done) break;
		end
		if (n == WAIT_LIMIT) begin
			$display("data access to 0x%h never completed", a);
			errors++;
			return;
		end
		rdata = data_rdata;
	endtask

	task automatic fill_table();
		stim[0]  = '{K_FETCH, 32'h0000_0100, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[1]  = '{K_FETCH, 32'h0000_0108, 32'h0, 32'h0, 4'h0, 1'b1};
		stim[2]  = '{K_FETCH, 32'h0000_010c, 32'h0, 32'h0, 4'h0, 1'b1};
		stim[3]  = '{K_STORE, 32'h0000_2000, 32'h0, 32'ha1b2_c3d4, 4'b0101, 1'b0};
		stim[4]  = '{K_LOAD,  32'h0000_2000, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[5]  = '{K_STORE, 32'h0000_2004, 32'h0, 32'h1234_5678, 4'b1111, 1'b0};
		stim[6]  = '{K_LOAD,  32'h0000_2004, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[7]  = '{K_STORE, 32'h0000_2000, 32'h0, 32'hffee_0099, 4'b1000, 1'b0};
		stim[8]  = '{K_PAIR,  32'h0000_0230, 32'h0000_2000, 32'h0, 4'h0, 1'b0};
		stim[9]  = '{K_FETCH, 32'h0000_0238, 32'h0, 32'h0, 4'h0, 1'b1};
		// three tags on index 5 with two ways
		stim[10] = '{K_FETCH, 32'h0000_0450, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[11] = '{K_FETCH, 32'h0000_1454, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[12] = '{K_FETCH, 32'h0000_2458, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[13] = '{K_FETCH, 32'h0000_045c, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[14] = '{K_FETCH, 32'h0000_1450, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[15] = '{K_FETCH, 32'h0000_2454, 32'h0, 32'h0, 4'h0, 1'b0};
		stim[16] = '{K_LOAD,  32'h0000_3008, 32'h0, 32'h0, 4'h0, 1'b0};
	endtask

	initial begin
		entry_t e;
		word_t  got, got2;
		int     lat, reads, base;
		errors     = 0;
		rst        = 1'b1;
		fetch_read = 1'b0;
		fetch_addr = '0;
		data_req   = 1'b0;
		data_we    = 1'b0;
		data_addr  = '0;
		data_wdata = '0;
		data_wstrb = '0;
		fill_table();

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_bit("fetch_stall", 1'b0, fetch_stall);
		check_bit("fetch_valid", 1'b0, fetch_valid);
		check_bit("data_busy", 1'b0, data_busy);
		check_bit("data_done", 1'b0, data_done);
		check_bit("m_arvalid", 1'b0, m_arvalid);
		check_bit("m_awvalid", 1'b0, m_awvalid);
		check_bit("m_wvalid", 1'b0, m_wvalid);
		check_bit("m_rready", 1'b0, m_rready);
		check_bit("m_bready", 1'b0, m_bready);
		$display("test 0 reset state: %s", (errors == 0) ? "ok" : "bad");

		for (int i = 0; i < NUM_TESTS; i++) begin
			e    = stim[i];
			base = errors;
			case (e.kind)
				K_FETCH: begin
					run_fetch(e.addr, got, lat, reads);
					check_word("fetch_data", expected_word(e.addr), got);
					if (e.hit) begin
						check_count("fetch_valid latency", 2, lat);
						check_count("m_arvalid handshakes", 0, reads);
					end
				end
				K_LOAD: begin
					run_data(1'b0, e.addr, '0, '0, got);
					check_word("data_rdata", expected_word(e.addr), got);
				end
				K_STORE: begin
					run_data(1'b1, e.addr, e.wdata, e.strb, got);
					record_store(e.addr, e.wdata, e.strb);
				end
				default: begin
					// fetch miss and load race for the bus
					fork
						run_fetch(e.addr, got, lat, reads);
						run_data(1'b0, e.addr2, '0, '0, got2);
					join
					check_word("fetch_data", expected_word(e.addr), got);
					check_word("data_rdata", expected_word(e.addr2), got2);
				end
			endcase
			$display("test %0d %s 0x%h: %s", i + 1, e.kind.name(), e.addr,
				(errors == base) ? "ok" : "bad");
		end

		$display("%0d tests run, %0d errors", NUM_TESTS + 1, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mem_subsys_top.f
cache_pkg.sv
single_port_ram.sv
icache.sv
data_port.sv
axi_lite_arbiter.sv
mem_subsys_top.sv
axi_lite_mem_model.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_subsys \
	-f mem_subsys_top.f \
	--Mdir obj_dir -o tb_mem_subsys
if [ $? -ne 0 ]; then
	echo "verilator build did not succeed"
	exit 1
fi

./obj_dir/tb_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
